// File: flist.f
UsiBusPkg.sv
CsrMapPkg.sv
MicroControllerCsr.sv
UsiBusController.sv
UsiRegFileSlave.sv
UsiAccumSlave.sv
UsiMasterTop.sv
UsiMasterTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the Usi bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module UsiMasterTb \
	--Mdir obj_dir -o simUsi \
	-f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simUsi > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see $LOG"
	exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// File: UsiMasterTb.sv
`timescale 1ns/1ps
`default_nettype none

module UsiMasterTb;

	logic                  iSysClk;
	logic                  rst;
	UsiBusPkg::usiData_t   iWd;
	CsrMapPkg::csrAdrs_t   iAdrs;
	logic                  iCke;
	UsiBusPkg::usiData_t   oRd;

	// Failure counters
	int mismatchCount;
	int timeoutCount;
	int propFailCount;

	logic [31:0] lcgState;

	// Scratch for the stimulus
	UsiBusPkg::usiData_t rdVal;
	UsiBusPkg::usiData_t regModel [16];
	UsiBusPkg::usiData_t accModel;
	UsiBusPkg::usiData_t wVal;
	UsiBusPkg::usiData_t zVal;
	CsrMapPkg::csrAdrs_t csrList [6];

	UsiMasterTop i_dut (
		.iSysClk (iSysClk),
		.rst     (rst),
		.iWd     (iWd),
		.iAdrs   (iAdrs),
		.iCke    (iCke),
		.oRd     (oRd)
	);

	// 40 ns period
	always #20 iSysClk = ~iSysClk;

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Select, read flag and word offset
	function automatic UsiBusPkg::usiAdrs_t busAddress(input logic [3:0] sel,
			input logic read, input logic [3:0] ofs);
		return {sel, read, 7'b0, ofs};
	endfunction

	task automatic checkEq(input string what, input UsiBusPkg::usiData_t got,
			input UsiBusPkg::usiData_t exp);
		assert (got === exp)
		else
		begin
			mismatchCount++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Entered right after a rising edge
	task automatic csrWrite(input CsrMapPkg::csrAdrs_t adrs, input UsiBusPkg::usiData_t data);
		iCke  <= 1'b1;
		iAdrs <= adrs;
		iWd   <= data;
		@(posedge iSysClk);
		iCke  <= 1'b0;
	endtask

	// oRd one cycle after the address, sampled mid cycle
	task automatic csrRead(input CsrMapPkg::csrAdrs_t adrs, output UsiBusPkg::usiData_t data);
		iCke  <= 1'b0;
		iAdrs <= adrs;
		@(posedge iSysClk);
		@(negedge iSysClk);
		data = oRd;
		@(posedge iSysClk);
	endtask

	// Poll busy with a 50 cycle limit
	task automatic waitIdle();
		UsiBusPkg::usiData_t stat;
		int cycles;
		cycles = 0;
		csrRead(CsrMapPkg::CsrStat, stat);
		while (stat[CsrMapPkg::StatBusy] && cycles < 50)
		begin
			csrRead(CsrMapPkg::CsrStat, stat);
			cycles += 2;
		end
		if (stat[CsrMapPkg::StatBusy])
		begin
			timeoutCount++;
			$display("Timeout at %0t: busy did not clear within 50 cycles", $time);
		end
	endtask

	task automatic busCmd(input UsiBusPkg::usiData_t wd, input UsiBusPkg::usiAdrs_t adrs);
		csrWrite(CsrMapPkg::CsrWd, wd);
		csrWrite(CsrMapPkg::CsrAdrs, UsiBusPkg::usiData_t'(adrs));
		csrWrite(CsrMapPkg::CsrWCke, 32'd1);
		waitIdle();
	endtask

	// ----------------------------------------
	// Protocol checks on the top level nets
	// ----------------------------------------
	aDoneNotBusy: assert property (@(posedge iSysClk) disable iff (rst)
		i_dut.done |-> !i_dut.busy)
	else
	begin
		propFailCount++;
		$display("MISMATCH at %0t: busy high together with done", $time);
	end

	// Strobe during a command must not start another
	aBusyStrobe: assert property (@(posedge iSysClk) disable iff (rst)
		(i_dut.busy && i_dut.busWCke) |=> !(i_dut.regCke || i_dut.accCke))
	else
	begin
		propFailCount++;
		$display("MISMATCH at %0t: strobe taken while busy", $time);
	end

	aRegLatency: assert property (@(posedge iSysClk) disable iff (rst)
		i_dut.regVd |-> $past(i_dut.regCke))
	else
	begin
		propFailCount++;
		$display("MISMATCH at %0t: register file valid not one cycle after cke", $time);
	end

	// Accumulator answers two cycles late
	aAccLatency: assert property (@(posedge iSysClk) disable iff (rst)
		i_dut.accVd |-> $past(i_dut.accCke, 2))
	else
	begin
		propFailCount++;
		$display("MISMATCH at %0t: accumulator valid not two cycles after cke", $time);
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial
	begin
		iSysClk       = 1'b0;
		rst           = 1'b1;
		iWd           = '0;
		iAdrs         = '0;
		iCke          = 1'b0;
		mismatchCount = 0;
		timeoutCount  = 0;
		propFailCount = 0;
		lcgState      = 32'haa71;
		csrList[0]    = CsrMapPkg::CsrWd;
		csrList[1]    = CsrMapPkg::CsrAdrs;
		csrList[2]    = CsrMapPkg::CsrWCke;
		csrList[3]    = CsrMapPkg::CsrRd;
		csrList[4]    = CsrMapPkg::CsrVd;
		csrList[5]    = CsrMapPkg::CsrStat;
		repeat (2) @(posedge iSysClk);
		rst <= 1'b0;

		// Everything zero after reset, busy included
		for (int i = 0; i < 6; i++)
		begin
			csrRead(csrList[i], rdVal);
			checkEq("reset value", rdVal, 32'd0);
		end

		// Manual registers read back, address cut to 16 bits
		for (int i = 0; i < 4; i++)
		begin
			wVal = nextRand();
			csrWrite(CsrMapPkg::CsrWd, wVal);
			csrRead(CsrMapPkg::CsrWd, rdVal);
			checkEq("CsrWd readback", rdVal, wVal);
			wVal = nextRand();
			csrWrite(CsrMapPkg::CsrAdrs, wVal);
			csrRead(CsrMapPkg::CsrAdrs, rdVal);
			checkEq("CsrAdrs readback", rdVal, wVal & 32'h0000_FFFF);
		end
		// Harmless read command before the strobe
		csrWrite(CsrMapPkg::CsrAdrs, UsiBusPkg::usiData_t'(busAddress(4'h0, 1'b1, 4'h0)));
		csrWrite(CsrMapPkg::CsrWCke, 32'd1);
		waitIdle();
		csrRead(CsrMapPkg::CsrWCke, rdVal);
		checkEq("CsrWCke self clear", rdVal, 32'd0);

		// Register file writes then reads
		for (int i = 0; i < 16; i += 3)
		begin
			regModel[i] = nextRand();
			busCmd(regModel[i], busAddress(4'h0, 1'b0, 4'(i)));
		end
		for (int i = 0; i < 16; i += 3)
		begin
			busCmd(32'd0, busAddress(4'h0, 1'b1, 4'(i)));
			csrRead(CsrMapPkg::CsrRd, rdVal);
			checkEq("register file read", rdVal, regModel[i]);
			csrRead(CsrMapPkg::CsrVd, rdVal);
			checkEq("register file valid bits", rdVal, 32'd1);
		end

		// Accumulator load, adds, then read
		accModel = nextRand();
		busCmd(accModel, busAddress(4'h1, 1'b0, 4'hF));
		for (int i = 0; i < 6; i++)
		begin
			wVal = nextRand();
			accModel = accModel + wVal;
			busCmd(wVal, busAddress(4'h1, 1'b0, 4'(i)));
		end
		busCmd(32'd0, busAddress(4'h1, 1'b1, 4'h0));
		csrRead(CsrMapPkg::CsrRd, rdVal);
		checkEq("accumulator sum", rdVal, accModel);
		csrRead(CsrMapPkg::CsrVd, rdVal);
		checkEq("accumulator valid bits", rdVal, 32'd2);

		// Unmapped select flags an error
		busCmd(nextRand(), busAddress(4'h5, 1'b1, 4'h2));
		csrRead(CsrMapPkg::CsrStat, rdVal);
		checkEq("status after unmapped", rdVal, 32'd2);
		csrRead(CsrMapPkg::CsrRd, rdVal);
		checkEq("read data after unmapped", rdVal, 32'd0);
		busCmd(32'd0, busAddress(4'h0, 1'b1, 4'h0));
		csrRead(CsrMapPkg::CsrStat, rdVal);
		checkEq("status after recovery", rdVal, 32'd0);

		// Second strobe lands in Wait and is dropped
		zVal = nextRand();
		busCmd(zVal, busAddress(4'h0, 1'b0, 4'h5));
		wVal = nextRand();
		if (wVal == zVal)
			wVal = ~zVal;
		csrWrite(CsrMapPkg::CsrWd, wVal);
		csrWrite(CsrMapPkg::CsrAdrs, UsiBusPkg::usiData_t'(busAddress(4'h0, 1'b0, 4'h4)));
		csrWrite(CsrMapPkg::CsrWCke, 32'd1);
		csrWrite(CsrMapPkg::CsrAdrs, UsiBusPkg::usiData_t'(busAddress(4'h0, 1'b0, 4'h5)));
		csrWrite(CsrMapPkg::CsrWCke, 32'd1);
		waitIdle();
		busCmd(32'd0, busAddress(4'h0, 1'b1, 4'h4));
		csrRead(CsrMapPkg::CsrRd, rdVal);
		checkEq("first command word", rdVal, wVal);
		busCmd(32'd0, busAddress(4'h0, 1'b1, 4'h5));
		csrRead(CsrMapPkg::CsrRd, rdVal);
		checkEq("word behind ignored strobe", rdVal, zVal);

		// Let the last properties settle
		repeat (3) @(posedge iSysClk);
		$display("Mismatches: %0d  Timeouts: %0d  Assertion failures: %0d",
			mismatchCount, timeoutCount, propFailCount);
		if (mismatchCount == 0 && timeoutCount == 0 && propFailCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: UsiMasterTop.sv
`timescale 1ns/1ps
`default_nettype none

module UsiMasterTop (
	input  wire logic                  iSysClk,
	input  wire logic                  rst,
	input  wire UsiBusPkg::usiData_t   iWd,
	input  wire CsrMapPkg::csrAdrs_t   iAdrs,
	input  wire logic                  iCke,
	output UsiBusPkg::usiData_t        oRd
);

	// CSR and controller
	UsiBusPkg::usiData_t busWd;
	UsiBusPkg::usiAdrs_t busAdrs;
	logic                busWCke;
	UsiBusPkg::usiData_t busRd;
	UsiBusPkg::usiVd_t   busVd;
	logic                done;
	logic                err;
	logic                busy;

	// Controller and slaves
	UsiBusPkg::usiData_t slvWd;
	UsiBusPkg::usiOfs_t  slvOfs;
	logic                slvRead;
	logic                regCke;
	logic                accCke;
	UsiBusPkg::usiData_t regRd;
	logic                regVd;
	UsiBusPkg::usiData_t accRd;
	logic                accVd;

	// --------------------------------------
	// Processor facing registers
	// --------------------------------------
	MicroControllerCsr uCsr (
		.iSysClk (iSysClk),
		.rst     (rst),
		.iWd     (iWd),
		.iAdrs   (iAdrs),
		.iCke    (iCke),
		.oRd     (oRd),
		.busWd   (busWd),
		.busAdrs (busAdrs),
		.busWCke (busWCke),
		.busRd   (busRd),
		.busVd   (busVd),
		.done    (done),
		.err     (err),
		.busy    (busy)
	);

	// --------------------------------------
	// Bus control
	// --------------------------------------
	UsiBusController uCtl (
		.iSysClk (iSysClk),
		.rst     (rst),
		.busWd   (busWd),
		.busAdrs (busAdrs),
		.busWCke (busWCke),
		.busRd   (busRd),
		.busVd   (busVd),
		.done    (done),
		.err     (err),
		.busy    (busy),
		.slvWd   (slvWd),
		.slvOfs  (slvOfs),
		.slvRead (slvRead),
		.regCke  (regCke),
		.accCke  (accCke),
		.regRd   (regRd),
		.regVd   (regVd),
		.accRd   (accRd),
		.accVd   (accVd)
	);

	// Slave 0
	UsiRegFileSlave uRegFile (
		.iSysClk (iSysClk),
		.rst     (rst),
		.cke     (regCke),
		.read    (slvRead),
		.ofs     (slvOfs),
		.wd      (slvWd),
		.rd      (regRd),
		.vd      (regVd)
	);

	// Slave 1
	UsiAccumSlave uAccum (
		.iSysClk (iSysClk),
		.rst     (rst),
		.cke     (accCke),
		.read    (slvRead),
		.ofs     (slvOfs),
		.wd      (slvWd),
		.rd      (accRd),
		.vd      (accVd)
	);

endmodule

`default_nettype wire

// File: UsiAccumSlave.sv
`timescale 1ns/1ps
`default_nettype none

module UsiAccumSlave (
	input  wire logic                  iSysClk,
	input  wire logic                  rst,
	input  wire logic                  cke,
	input  wire logic                  read,
	input  wire UsiBusPkg::usiOfs_t    ofs,
	input  wire UsiBusPkg::usiData_t   wd,
	output UsiBusPkg::usiData_t        rd,
	output logic                       vd
);

	// Stage 1 command copy
	logic                ckeQ;
	logic                readQ;
	logic                loadQ;
	UsiBusPkg::usiData_t wdQ;

	UsiBusPkg::usiData_t acc;
	UsiBusPkg::usiData_t accNext;

	// --------------------------------------
	// Stage 1
	// --------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			ckeQ <= 1'b0;
		else
			ckeQ <= cke;
	end

	always_ff @(posedge iSysClk)
	begin
		readQ <= read;
		// Top offset loads instead of adding
		loadQ <= (ofs == '1);
		wdQ   <= wd;
	end

	// Sum wraps modulo 2^32
	assign accNext = loadQ ? wdQ : acc + wdQ;

	// --------------------------------------
	// Stage 2
	// --------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			acc <= '0;
			vd  <= 1'b0;
		end
		else
		begin
			vd <= ckeQ;
			if (ckeQ && !readQ)
				acc <= accNext;
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (ckeQ)
			rd <= readQ ? acc : accNext;
	end

endmodule

`default_nettype wire

// File: UsiRegFileSlave.sv
`timescale 1ns/1ps
`default_nettype none

module UsiRegFileSlave (
	input  wire logic                  iSysClk,
	input  wire logic                  rst,
	input  wire logic                  cke,
	input  wire logic                  read,
	input  wire UsiBusPkg::usiOfs_t    ofs,
	input  wire UsiBusPkg::usiData_t   wd,
	output UsiBusPkg::usiData_t        rd,
	output logic                       vd
);

	// --------------------------------------
	// Register array
	// --------------------------------------
	UsiBusPkg::usiData_t mem [UsiBusPkg::RegNum];

	// Storage and read data
	always_ff @(posedge iSysClk)
	begin
		if (cke)
		begin
			if (read)
				rd <= mem[ofs];
			else
			begin
				mem[ofs] <= wd;
				// Echo of the written word
				rd       <= wd;
			end
		end
	end

	// One cycle answer
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			vd <= 1'b0;
		else
			vd <= cke;
	end

endmodule

`default_nettype wire

// File: UsiBusController.sv
`timescale 1ns/1ps
`default_nettype none

module UsiBusController (
	input  wire logic                  iSysClk,
	input  wire logic                  rst,
	// Command from the CSR
	input  wire UsiBusPkg::usiData_t   busWd,
	input  wire UsiBusPkg::usiAdrs_t   busAdrs,
	input  wire logic                  busWCke,
	// Result to the CSR
	output UsiBusPkg::usiData_t        busRd,
	output UsiBusPkg::usiVd_t          busVd,
	output logic                       done,
	output logic                       err,
	output logic                       busy,
	// Shared slave command
	output UsiBusPkg::usiData_t        slvWd,
	output UsiBusPkg::usiOfs_t         slvOfs,
	output logic                       slvRead,
	// Per slave strobes and answers
	output logic                       regCke,
	output logic                       accCke,
	input  wire UsiBusPkg::usiData_t   regRd,
	input  wire logic                  regVd,
	input  wire UsiBusPkg::usiData_t   accRd,
	input  wire logic                  accVd
);

	typedef enum logic [1:0] {Idle, Issue, Wait, Done} ctlState_t;

	ctlState_t state;

	// Latched command
	UsiBusPkg::usiSel_t  selQ;
	UsiBusPkg::usiOfs_t  ofsQ;
	UsiBusPkg::usiData_t wdQ;
	logic                readQ;
	logic                errQ;

	// Captured answer
	UsiBusPkg::usiData_t rdQ;
	UsiBusPkg::usiVd_t   vdQ;

	// Decode of the latched select
	logic                isReg;
	logic                isAcc;
	logic                slvVd;
	UsiBusPkg::usiData_t slvRd;
	UsiBusPkg::usiVd_t   vdNow;

	assign isReg = (selQ == UsiBusPkg::SelRegFile);
	assign isAcc = (selQ == UsiBusPkg::SelAccum);

	// Answer of the selected slave only
	assign slvVd = (isReg && regVd) || (isAcc && accVd);
	assign slvRd = isAcc ? accRd : regRd;

	always_comb
	begin
		vdNow = '0;
		vdNow[int'(UsiBusPkg::SelRegFile)] = regVd;
		vdNow[int'(UsiBusPkg::SelAccum)]   = accVd;
	end

	// --------------------------------------
	// Control FSM
	// --------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			state <= Idle;
			errQ  <= 1'b0;
		end
		else
		begin
			case (state)
				Idle:
					// Strobes outside Idle are dropped
					if (busWCke)
					begin
						state <= Issue;
						errQ  <= 1'b0;
					end
				Issue:
					if (isReg || isAcc)
						state <= Wait;
					else
					begin
						// Unmapped select finishes at once
						state <= Done;
						errQ  <= 1'b1;
					end
				Wait:
					if (slvVd)
						state <= Done;
				Done:
					state <= Idle;
				default:
					state <= Idle;
			endcase
		end
	end

	// Command latch and answer capture
	always_ff @(posedge iSysClk)
	begin
		if (state == Idle && busWCke)
		begin
			selQ  <= busAdrs[UsiBusPkg::SelMsb:UsiBusPkg::SelLsb];
			readQ <= busAdrs[UsiBusPkg::ReadBit];
			ofsQ  <= busAdrs[UsiBusPkg::OfsMsb:0];
			wdQ   <= busWd;
		end
		if (state == Issue && !(isReg || isAcc))
		begin
			rdQ <= '0;
			vdQ <= '0;
		end
		else if (state == Wait && slvVd)
		begin
			rdQ <= slvRd;
			vdQ <= vdNow;
		end
	end

	// Strobe goes out in Issue only
	assign regCke = (state == Issue) && isReg;
	assign accCke = (state == Issue) && isAcc;

	assign slvWd   = wdQ;
	assign slvOfs  = ofsQ;
	assign slvRead = readQ;

	assign busRd = rdQ;
	assign busVd = vdQ;
	assign err   = errQ;
	assign done  = (state == Done);
	// Low again in the done cycle
	assign busy  = (state == Issue) || (state == Wait);

	aOneCke: assert property (@(posedge iSysClk) disable iff (rst)
		$onehot0({regCke, accCke}));

	aDoneIdle: assert property (@(posedge iSysClk) disable iff (rst)
		done |=> (state == Idle));

endmodule

`default_nettype wire

// File: MicroControllerCsr.sv
`timescale 1ns/1ps
`default_nettype none

module MicroControllerCsr (
	input  wire logic                  iSysClk,
	input  wire logic                  rst,
	// Processor side
	input  wire UsiBusPkg::usiData_t   iWd,
	input  wire CsrMapPkg::csrAdrs_t   iAdrs,
	input  wire logic                  iCke,
	output UsiBusPkg::usiData_t        oRd,
	// Command to the bus controller
	output UsiBusPkg::usiData_t        busWd,
	output UsiBusPkg::usiAdrs_t        busAdrs,
	output logic                       busWCke,
	// Result from the bus controller
	input  wire UsiBusPkg::usiData_t   busRd,
	input  wire UsiBusPkg::usiVd_t     busVd,
	input  wire logic                  done,
	input  wire logic                  err,
	input  wire logic                  busy
);

	// Write decode
	logic wrWd;
	logic wrAdrs;
	logic wrWCke;

	// Auto registers
	UsiBusPkg::usiData_t rdQ;
	UsiBusPkg::usiVd_t   vdQ;
	logic                errQ;

	// Status word
	UsiBusPkg::usiData_t stat;

	assign wrWd   = iCke && (iAdrs == CsrMapPkg::CsrWd);
	assign wrAdrs = iCke && (iAdrs == CsrMapPkg::CsrAdrs);
	assign wrWCke = iCke && (iAdrs == CsrMapPkg::CsrWCke);

	// --------------------------------------
	// Manual and auto registers
	// --------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			busWd   <= '0;
			busAdrs <= '0;
			busWCke <= 1'b0;
			rdQ     <= '0;
			vdQ     <= '0;
			errQ    <= 1'b0;
		end
		else
		begin
			if (wrWd)
				busWd <= iWd;
			// Upper bits dropped
			if (wrAdrs)
				busAdrs <= iWd[UsiBusPkg::AdrsWidth-1:0];
			// Strobe clears itself the next cycle
			busWCke <= wrWCke && iWd[0] && !busWCke;
			// Latch the result on done
			if (done)
			begin
				rdQ <= busRd;
				vdQ <= busVd;
			end
			// Sticky error, a new strobe starts clean
			if (busWCke)
				errQ <= 1'b0;
			else if (done && err)
				errQ <= 1'b1;
		end
	end

	// Strobe counts as busy until the controller picks it up
	always_comb
	begin
		stat = '0;
		stat[CsrMapPkg::StatBusy] = busy || busWCke;
		stat[CsrMapPkg::StatErr]  = errQ;
	end

	// --------------------------------------
	// Registered read mux
	// --------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			oRd <= '0;
		else
		begin
			case (iAdrs)
				CsrMapPkg::CsrWd:   oRd <= busWd;
				CsrMapPkg::CsrAdrs: oRd <= UsiBusPkg::usiData_t'(busAdrs);
				CsrMapPkg::CsrWCke: oRd <= UsiBusPkg::usiData_t'(busWCke);
				CsrMapPkg::CsrRd:   oRd <= rdQ;
				CsrMapPkg::CsrVd:   oRd <= UsiBusPkg::usiData_t'(vdQ);
				CsrMapPkg::CsrStat: oRd <= stat;
				// Unmapped keeps last value
				default:            oRd <= oRd;
			endcase
		end
	end

	// Strobe is a single pulse even on back to back writes
	aStrobePulse: assert property (@(posedge iSysClk) disable iff (rst)
		busWCke |=> !busWCke);

endmodule

`default_nettype wire

// File: CsrMapPkg.sv
`default_nettype none

package CsrMapPkg;

	typedef logic [7:0] csrAdrs_t;

	// --------------------------------------
	// CSR address map
	// --------------------------------------
	// Manual registers
	localparam csrAdrs_t CsrWd   = 8'h00;
	localparam csrAdrs_t CsrAdrs = 8'h04;
	localparam csrAdrs_t CsrWCke = 8'h08;
	// Auto registers, read only
	localparam csrAdrs_t CsrRd   = 8'h0C;
	localparam csrAdrs_t CsrVd   = 8'h10;
	localparam csrAdrs_t CsrStat = 8'h14;

	// --------------------------------------
	// Status bits of CsrStat
	// --------------------------------------
	localparam int StatBusy = 0;
	localparam int StatErr  = 1;

endpackage

`default_nettype wire

// File: UsiBusPkg.sv
`default_nettype none

package UsiBusPkg;

	// --------------------------------------
	// Bus widths
	// --------------------------------------
	localparam int DataWidth = 32;
	localparam int AdrsWidth = 16;
	localparam int SlaveNum  = 2;
	localparam int RegNum    = 16;

	// Address fields
	localparam int SelMsb  = 15;
	localparam int SelLsb  = 12;
	localparam int ReadBit = 11;
	localparam int OfsMsb  = 3;

	typedef logic [DataWidth-1:0]     usiData_t;
	typedef logic [AdrsWidth-1:0]     usiAdrs_t;
	typedef logic [SlaveNum-1:0]      usiVd_t;
	typedef logic [SelMsb-SelLsb:0]   usiSel_t;
	typedef logic [OfsMsb:0]          usiOfs_t;

	// Slave select codes, the rest unmapped
	localparam usiSel_t SelRegFile = 4'd0;
	localparam usiSel_t SelAccum   = 4'd1;

endpackage

`default_nettype wire
